// ==== tb.f ====
source/border_pkg.sv
source/raster_tracker.sv
source/border_keys.sv
source/blank_shaper.sv
source/mode_watch.sv
source/border_top.sv
bench/video_source.sv
bench/tb_border.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -f tb.f --top-module tb_border -o sim_border
./obj_dir/sim_border | tee sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== bench/tb_border.sv ====
// Testbench for the border trimmer; drives a raster and key events, checks snapshots and de
`timescale 1ns/10ps

module tb_border;
	import border_pkg::*;

	localparam int key_h_step     = 4;
	localparam int force_h_margin = 8;
	localparam int snap_timeout   = 3000;  // Cycles, over two frames

	logic            clk_sys = 1'b0;
	logic            reset;
	raw_video_t      video;
	kbd_event_t      kbd;
	logic            preset_load;
	border_offsets_t preset;
	logic            de;
	screen_snap_t    snap;
	logic [6:0]      change_count;
	coord_t          set_width;
	coord_t          set_lines;
	res_t            set_res;
	border_offsets_t model_off;
	logic            model_alt;
	screen_geom_t    last_geom;
	logic [6:0]      exp_count;
	int              snap_index;
	int              hs_age;  // Sampled edges since hs went high
	logic [31:0]     lcg_state;

	always #4 clk_sys = ~clk_sys;

	video_source video_source_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.width   (set_width),
		.lines   (set_lines),
		.res     (set_res),
		.video   (video)
	);

	border_top #(.key_h_step(key_h_step), .force_h_margin(force_h_margin)) dut_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.video        (video),
		.kbd          (kbd),
		.preset_load  (preset_load),
		.preset       (preset),
		.de           (de),
		.snap         (snap),
		.change_count (change_count)
	);

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk_sys or posedge reset) begin
		if (reset)
			hs_age <= 0;
		else
			hs_age <= video.hs ? hs_age + 1 : 0;
	end

	// Margin cycles plus the output register
	a_de_margin: assert property (@(posedge clk_sys) disable iff (reset)
		de |-> (video.hs && hs_age > force_h_margin + 1))
		else stop_with_error($sformatf("Mismatch at %0t: de high, hs %b, %0d cycles after hs rise",
			$time, video.hs, hs_age));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic coord_t rand_coord();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[27:16];
	endfunction

	task automatic next_drive_slot();
		@(posedge clk_sys);
		#1;
	endtask

	// Border rules as seen from the keyboard
	task automatic model_key(input logic [7:0] code);
		case (code)
			key_backspace: model_off = '0;
			key_up:    if (model_alt) model_off.vbl_b = model_off.vbl_b + coord_t'(1);
			           else model_off.vbl_t = model_off.vbl_t + coord_t'(1);
			key_down:  if (model_alt) model_off.vbl_b = model_off.vbl_b - coord_t'(1);
			           else model_off.vbl_t = model_off.vbl_t - coord_t'(1);
			key_left:  if (model_alt) model_off.hbl_r = model_off.hbl_r + coord_t'(key_h_step);
			           else model_off.hbl_l = model_off.hbl_l + coord_t'(key_h_step);
			key_right: if (model_alt) model_off.hbl_r = model_off.hbl_r - coord_t'(key_h_step);
			           else model_off.hbl_l = model_off.hbl_l - coord_t'(key_h_step);
			key_alt_l, key_alt_r: model_alt = 1'b1;
			key_alt_l_up, key_alt_r_up: model_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic send_random_keys(input int count);
		int         pick;
		logic [7:0] code;
		for (int i = 0; i < count; i++) begin
			lcg_state = lcg_next(lcg_state);
			pick = int'(lcg_state[23:16]) % 6;
			case (pick)
				0: code = key_up;
				1: code = key_down;
				2: code = key_left;
				3: code = key_right;
				4: if (model_alt) code = lcg_state[24] ? key_alt_l_up : key_alt_r_up;
				   else code = lcg_state[24] ? key_alt_l : key_alt_r;
				default: code = key_backspace;
			endcase
			next_drive_slot();
			kbd = '{level: ~kbd.level, kind: kbd_type_key, code: code};
			model_key(code);
			repeat (2) next_drive_slot();
		end
	endtask

	task automatic wait_snap(input bit idle_check);
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < snap_timeout) begin
			@(posedge clk_sys);
			if (idle_check)
				assert (de == 1'b0 && change_count == 7'd0)
				else stop_with_error($sformatf("Mismatch at %0t: de %b, change_count %0d before first frame",
					$time, de, change_count));
			seen   = dut_i.vblank_end;
			cycles = cycles + 1;
		end
		if (!seen)
			stop_with_error("Timeout: the end of vertical blanking never came");
		#2;  // Snapshot registers settle
	endtask

	// Geometry belongs to the frame that holds the snapshot, height to the one before
	task automatic check_snap();
		screen_geom_t exp_geom;
		exp_geom.hsize = set_width;
		exp_geom.vsize = (snap_index == 0) ? '0 : set_lines;
		exp_geom.res   = set_res;
		if (exp_geom != last_geom)
			exp_count = exp_count + 7'd1;
		last_geom  = exp_geom;
		snap_index = snap_index + 1;
		assert (snap.geom == exp_geom)
		else stop_with_error($sformatf("Mismatch at %0t: geom %h, expected %h",
			$time, snap.geom, exp_geom));
		assert (snap.offsets == model_off)
		else stop_with_error($sformatf("Mismatch at %0t: offsets %h, expected %h",
			$time, snap.offsets, model_off));
		assert (change_count == exp_count)
		else stop_with_error($sformatf("Mismatch at %0t: change_count %0d, expected %0d",
			$time, change_count, exp_count));
	endtask

	initial begin
		reset       = 1'b1;
		kbd         = '0;
		preset_load = 1'b0;
		preset      = '0;
		set_width   = coord_t'(32);
		set_lines   = coord_t'(14);
		set_res     = 2'd0;
		model_off   = '0;
		model_alt   = 1'b0;
		last_geom   = '0;
		exp_count   = 7'd0;
		snap_index  = 0;
		lcg_state   = 32'd15;
		repeat (3) next_drive_slot();
		reset = 1'b0;

		wait_snap(1'b1);
		check_snap();
		wait_snap(1'b0);  // First full height
		check_snap();

		send_random_keys(24);
		wait_snap(1'b0);
		check_snap();

		next_drive_slot();
		// Left border opens before the forced margin ends, rows stay inside the frame
		preset.vbl_t = rand_coord() & coord_t'(3);
		preset.vbl_b = coord_t'(-2) - (rand_coord() & coord_t'(3));
		preset.hbl_l = coord_t'(-8) + (rand_coord() & coord_t'(7));
		preset.hbl_r = rand_coord() & coord_t'(7);
		preset_load = 1'b1;
		kbd = '{level: ~kbd.level, kind: kbd_type_key, code: key_up};
		next_drive_slot();
		preset_load = 1'b0;
		model_off   = preset;
		wait_snap(1'b0);
		check_snap();

		set_res = 2'd1;
		wait_snap(1'b0);
		check_snap();
		wait_snap(1'b0);
		check_snap();
		set_width = coord_t'(40);
		wait_snap(1'b0);
		check_snap();
		wait_snap(1'b0);
		check_snap();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== bench/video_source.sv ====
// Testbench raster generator; active width, active lines and resolution are taken at each frame start
`timescale 1ns/10ps

module video_source (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  border_pkg::coord_t     width,
	input  border_pkg::coord_t     lines,
	input  border_pkg::res_t       res,
	output border_pkg::raw_video_t video
);
	import border_pkg::*;

	localparam int h_total = 64;
	localparam int hs_len  = 6;
	localparam int h_start = 16;  // First active pixel of a line
	localparam int v_bl    = 6;   // Blank lines at the top of each frame

	int     p = 0;
	int     l = 0;
	logic   in_reset;
	coord_t cur_width = '0;
	coord_t cur_lines = '0;
	res_t   cur_res = '0;

	always @(posedge clk_sys) begin
		in_reset = reset;  // Taken at the edge, before the drive delay
		#1;
		if (in_reset) begin
			p = 0;
			l = 0;
		end else if (p == h_total - 1) begin
			p = 0;
			l = (l == v_bl + int'(cur_lines) - 1) ? 0 : l + 1;
		end else begin
			p = p + 1;
		end
		if (p == 0 && l == 0) begin
			cur_width = width;
			cur_lines = lines;
			cur_res   = res;
		end
	end

	always_comb begin
		video.hs     = (p >= hs_len);
		video.vs     = !(l == 2 || l == 3);  // Sync inside the top blanking
		video.hblank = !(p >= h_start && p < h_start + int'(cur_width));
		video.vblank = (l < v_bl);
		video.res    = cur_res;
	end

endmodule

// ==== source/border_top.sv ====
// Border trimmer top; connects raster tracking, key control, blanking and mode watch
`timescale 1ns/10ps

module border_top #(
	parameter int key_h_step     = 4,
	parameter int force_h_margin = 8
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  border_pkg::raw_video_t      video,
	input  border_pkg::kbd_event_t      kbd,
	input  logic                        preset_load,
	input  border_pkg::border_offsets_t preset,
	output logic                        de,
	output border_pkg::screen_snap_t    snap,
	output logic [6:0]                  change_count
);
	import border_pkg::*;

	raster_pos_t     pos;
	raster_marks_t   marks;
	screen_geom_t    geom;
	border_offsets_t offsets;
	logic            hs_fall;
	logic            vblank_end;

	raster_tracker raster_tracker_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.video      (video),
		.pos        (pos),
		.marks      (marks),
		.geom       (geom),
		.hs_fall    (hs_fall),
		.vblank_end (vblank_end)
	);

	border_keys #(.key_h_step(key_h_step)) border_keys_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.kbd         (kbd),
		.preset_load (preset_load),
		.preset      (preset),
		.offsets     (offsets)
	);

	blank_shaper #(.force_h_margin(force_h_margin)) blank_shaper_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.video   (video),
		.pos     (pos),
		.marks   (marks),
		.offsets (offsets),
		.hs_fall (hs_fall),
		.de      (de)
	);

	mode_watch mode_watch_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.vblank_end   (vblank_end),
		.offsets      (offsets),
		.geom         (geom),
		.snap         (snap),
		.change_count (change_count)
	);

endmodule

// ==== source/mode_watch.sv ====
// Per-frame snapshot of borders and geometry with a count of screen mode changes
`timescale 1ns/10ps

module mode_watch (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        vblank_end,
	input  border_pkg::border_offsets_t offsets,
	input  border_pkg::screen_geom_t    geom,
	output border_pkg::screen_snap_t    snap,
	output logic [6:0]                  change_count
);
	import border_pkg::*;

	logic mode_diff;

	// Compared against the previous snapshot, not the live inputs
	assign mode_diff = (geom.res   != snap.geom.res)   ||
	                   (geom.hsize != snap.geom.hsize) ||
	                   (geom.vsize != snap.geom.vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			snap <= '0;
		end else if (vblank_end) begin
			snap.offsets <= offsets;
			snap.geom    <= geom;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			change_count <= '0;
		else if (vblank_end && mode_diff)
			change_count <= change_count + 7'd1;  // Wraps after 127
	end

endmodule

// ==== source/blank_shaper.sv ====
// Trimmed and forced blanking around the measured raster; produces the registered display enable
`timescale 1ns/10ps

module blank_shaper #(
	parameter int force_h_margin = 8
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  border_pkg::raw_video_t      video,
	input  border_pkg::raster_pos_t     pos,
	input  border_pkg::raster_marks_t   marks,
	input  border_pkg::border_offsets_t offsets,
	input  logic                        hs_fall,
	output logic                        de
);
	import border_pkg::*;

	logic   shbl;     // Soft, from the key offsets
	logic   fhbl;     // Forced edge margin
	logic   svbl;
	logic   fvbl;
	logic   hbl;
	logic   old_hbl;
	logic   v_eval;
	coord_t margin;
	coord_t vbl_b_line;

	assign margin = coord_t'(force_h_margin);
	assign hbl    = fhbl | shbl | ~video.hs;

	// Bottom border counts back from vmax when its top bit is set
	assign vbl_b_line = offsets.vbl_b[coord_w-1] ? marks.vmax + offsets.vbl_b : offsets.vbl_b;

	assign v_eval = old_hbl & ~hbl;

	// Blanked out of reset until the raster has been measured
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (hs_fall) begin
				shbl <= 1'b1;  // Re-arm at every line end
				fhbl <= 1'b1;
			end
			if (pos.hcnt == marks.hend + offsets.hbl_l - coord_t'(2)) shbl <= 1'b0;
			if (pos.hcnt == marks.hsta + offsets.hbl_r - coord_t'(2)) shbl <= 1'b1;

			if (pos.hcnt == margin && marks.hmax != '0) fhbl <= 1'b0;
			if (pos.hcnt == marks.hmax - margin)        fhbl <= 1'b1;
		end
	end

	// Vertical state moves only at the start of active video
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			svbl    <= 1'b1;
			fvbl    <= 1'b0;
			old_hbl <= 1'b1;
		end else begin
			old_hbl <= hbl;
			if (v_eval) begin
				if (pos.vcnt == marks.vend + offsets.vbl_t) svbl <= 1'b0;
				if (pos.vcnt == vbl_b_line)                 svbl <= 1'b1;

				if (pos.vcnt == marks.vmax - coord_t'(1))   fvbl <= 1'b1;
				if (pos.vcnt == marks.vs_end + coord_t'(2)) fvbl <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			de <= 1'b0;
		else
			de <= ~(hbl | svbl | fvbl | ~video.vs);
	end

	// Relies on fhbl closing before the sync that hmax predicts
	a_de_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!video.hs |-> !de)
		else $error("display enable high during horizontal sync");

endmodule

// ==== source/border_keys.sv ====
// Keyboard driven border offsets with preset load; alt selects bottom and right borders
`timescale 1ns/10ps

module border_keys #(
	parameter int key_h_step = 4
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  border_pkg::kbd_event_t      kbd,
	input  logic                        preset_load,
	input  border_pkg::border_offsets_t preset,
	output border_pkg::border_offsets_t offsets
);
	import border_pkg::*;

	logic   old_level;
	logic   alt;
	logic   key_hit;
	coord_t h_step;

	assign h_step  = coord_t'(key_h_step);
	assign key_hit = (old_level ^ kbd.level) && (kbd.kind == kbd_type_key);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt       <= 1'b0;
		end else begin
			old_level <= kbd.level;
			if (key_hit) begin
				if (kbd.code == key_alt_l || kbd.code == key_alt_r)
					alt <= 1'b1;
				else if (kbd.code == key_alt_l_up || kbd.code == key_alt_r_up)
					alt <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			offsets <= '0;
		end else if (preset_load) begin
			offsets <= preset;  // Wins over a key in the same cycle
		end else if (key_hit) begin
			case (kbd.code)
				key_backspace: offsets <= '0;
				key_up: begin
					if (alt) offsets.vbl_b <= offsets.vbl_b + coord_t'(1);
					else     offsets.vbl_t <= offsets.vbl_t + coord_t'(1);
				end
				key_down: begin
					if (alt) offsets.vbl_b <= offsets.vbl_b - coord_t'(1);
					else     offsets.vbl_t <= offsets.vbl_t - coord_t'(1);
				end
				key_left: begin
					if (alt) offsets.hbl_r <= offsets.hbl_r + h_step;
					else     offsets.hbl_l <= offsets.hbl_l + h_step;
				end
				key_right: begin
					if (alt) offsets.hbl_r <= offsets.hbl_r - h_step;
					else     offsets.hbl_l <= offsets.hbl_l - h_step;
				end
				default: ;  // Other keys leave the borders alone
			endcase
		end
	end

	a_preset_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		preset_load |=> !preset_load)
		else $error("preset_load held for more than one cycle");

endmodule

// ==== source/raster_tracker.sv ====
// Raster position counters and edge marks; measures the active picture once per line and frame
`timescale 1ns/10ps

module raster_tracker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  border_pkg::raw_video_t    video,
	output border_pkg::raster_pos_t   pos,
	output border_pkg::raster_marks_t marks,
	output border_pkg::screen_geom_t  geom,
	output logic                      hs_fall,
	output logic                      vblank_end
);
	import border_pkg::*;

	logic old_hs;
	logic old_vs;
	logic old_hblank;
	logic old_vbl;
	logic vbl;
	logic hbl_rise;
	logic hbl_fall;
	logic vbl_rise;
	logic vbl_fall;
	logic vs_rise;

	assign vbl = video.vblank | ~video.vs;  // Sync counts as vertical blanking

	assign hs_fall  = old_hs & ~video.hs;
	assign vs_rise  = ~old_vs & video.vs;
	assign hbl_rise = ~old_hblank & video.hblank;
	assign hbl_fall = old_hblank & ~video.hblank;
	assign vbl_rise = ~old_vbl & vbl;
	assign vbl_fall = old_vbl & ~vbl;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b0;
			old_vs     <= 1'b0;
			old_hblank <= 1'b0;
			old_vbl    <= 1'b0;
			vblank_end <= 1'b0;
		end else begin
			old_hs     <= video.hs;
			old_vs     <= video.vs;
			old_hblank <= video.hblank;
			old_vbl    <= vbl;
			vblank_end <= vbl_fall;  // One cycle after the fall
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pos <= '0;
		end else begin
			if (!video.hs)
				pos.hcnt <= '0;  // Held at zero through sync
			else
				pos.hcnt <= pos.hcnt + coord_t'(1);

			if (vbl_rise)
				pos.vcnt <= '0;
			else if (hs_fall)
				pos.vcnt <= pos.vcnt + coord_t'(1);
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			marks <= '0;
		end else begin
			if (hbl_fall) marks.hend <= pos.hcnt;
			if (hbl_rise) marks.hsta <= pos.hcnt;
			if (hs_fall)  marks.hmax <= pos.hcnt;
			if (vbl_fall) marks.vend <= pos.vcnt;
			if (vbl_rise) marks.vmax <= pos.vcnt;
			if (vs_rise)  marks.vs_end <= pos.vcnt;
		end
	end

	// Line 1 gives the width, the vblank rise closes the height
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			geom <= '0;
		end else begin
			if (hbl_rise && pos.vcnt == coord_t'(1))
				geom.hsize <= pos.hcnt - marks.hend;  // hcnt is the new hsta here
			if (vbl_rise) begin
				geom.vsize <= pos.vcnt - marks.vend;
				geom.res   <= video.res;
			end
		end
	end

	// Width marks assume the counter restart lies inside blanking
	a_sync_in_blank: assert property (@(posedge clk_sys) disable iff (reset)
		!video.hs |-> video.hblank)
		else $error("horizontal sync outside horizontal blanking");

endmodule

// ==== source/border_pkg.sv ====
// Shared types and key codes that every border trimmer module imports
package border_pkg;

	localparam int coord_w = 12;  // All pixel and line coordinates

	// Raw keycodes from the host keyboard stream
	localparam logic [7:0] key_backspace = 8'h41;
	localparam logic [7:0] key_up        = 8'h4c;
	localparam logic [7:0] key_down      = 8'h4d;
	localparam logic [7:0] key_right     = 8'h4e;
	localparam logic [7:0] key_left      = 8'h4f;
	localparam logic [7:0] key_alt_l     = 8'h64;
	localparam logic [7:0] key_alt_r     = 8'h65;
	localparam logic [7:0] key_alt_l_up  = 8'he4;  // Break codes
	localparam logic [7:0] key_alt_r_up  = 8'he5;

	localparam logic [1:0] kbd_type_key = 2'd3;  // Event kind for keys

	typedef logic [coord_w-1:0] coord_t;

	typedef logic [1:0] res_t;  // Bit 0 hires, bit 1 superhires

	typedef struct packed {
		logic hs;      // Active low
		logic vs;      // Active low
		logic hblank;
		logic vblank;
		res_t res;
	} raw_video_t;

	typedef struct packed {
		logic       level;  // Toggles once per event
		logic [1:0] kind;
		logic [7:0] code;
	} kbd_event_t;

	// Top bit of vbl_b set means counted back from the last line
	typedef struct packed {
		coord_t vbl_t;
		coord_t vbl_b;
		coord_t hbl_l;
		coord_t hbl_r;
	} border_offsets_t;

	typedef struct packed {
		coord_t hcnt;
		coord_t vcnt;
	} raster_pos_t;

	typedef struct packed {
		coord_t hend;    // Active video start in the line
		coord_t hsta;    // Active video stop in the line
		coord_t hmax;
		coord_t vend;
		coord_t vmax;
		coord_t vs_end;
	} raster_marks_t;

	typedef struct packed {
		coord_t hsize;
		coord_t vsize;
		res_t   res;
	} screen_geom_t;

	typedef struct packed {
		border_offsets_t offsets;
		screen_geom_t    geom;
	} screen_snap_t;

endpackage
